//--- filelist.f
common/mips_pkg.sv
decode/instr_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/step_ctrl.sv
logic/exec_core.sv
+incdir+tb
tb/exec_core_chk.sv
tb/exec_core_monitor.sv
tb/tb_exec_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/check_kinds.svh
// check kinds carried by each stimulus table entry
localparam logic [3:0] K_NONE     = 4'd0;   // no check, setup only
localparam logic [3:0] K_WDATA    = 4'd1;   // sw, mem_wdata against exp
localparam logic [3:0] K_ADDR     = 4'd2;   // sw, mem_addr against exp
localparam logic [3:0] K_BRANCH   = 4'd3;   // redirect taken to exp
localparam logic [3:0] K_NOBRANCH = 4'd4;
localparam logic [3:0] K_JUMP     = 4'd5;
localparam logic [3:0] K_HALT     = 4'd6;
localparam logic [3:0] K_NOWRITE  = 4'd7;   // sw after halt, no memory cycle

//--- tb/tb_exec_core.sv
module tb_exec_core;
    import mips_pkg::*;
    `include "check_kinds.svh"

    logic              clk;
    logic              rst_b;
    logic [XLEN-1:0]   instr;
    logic [XLEN-1:0]   mem_rdata;
    logic [XLEN-1:0]   mem_addr;
    logic [XLEN-1:0]   mem_wdata;
    logic              mem_we;
    logic [XLEN-1:0]   pc_branch;
    logic              pc_branch_en;
    logic [PC_J_W-1:0] pc_j;
    logic              pc_j_en;
    logic              halted_signal;
    logic              wait_sig;
    logic              run_done;
    int                entry_id;
    logic [3:0]        cur_kind;
    logic [XLEN-1:0]   cur_exp;
    int                n_tests;
    int                n_errors;
    int                seed;
    int                cycles = 0;

    // stimulus table
    logic [XLEN-1:0] tbl_instr [64];
    logic [XLEN-1:0] tbl_rdata [64];
    logic [3:0]      tbl_kind [64];
    logic [XLEN-1:0] tbl_exp [64];
    int              n_entries = 0;
    int              n_checks = 0;
    logic [XLEN-1:0] model [NUM_REGS];   // expected register contents

    exec_core UUT (.*);

    exec_core_monitor u_monitor (.*, .kind(cur_kind), .exp(cur_exp));

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (n_entries > 0 && cycles > n_entries * (MEM_WAIT_CYCLES + 2) + 50) begin
            $display("timeout: the drive loop did not finish in time");
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] enc_i(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] enc_r(logic [5:0] fn, int rs, int rt, int rd, int sh);
        return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    task automatic add_entry(logic [31:0] ins, logic [31:0] rdata, logic [3:0] kind,
                             logic [31:0] exp);
        tbl_instr[n_entries] = ins;
        tbl_rdata[n_entries] = rdata;
        tbl_kind[n_entries]  = kind;
        tbl_exp[n_entries]   = exp;
        n_entries++;
        if (kind != K_NONE) n_checks++;
    endtask

    task automatic put_alu(logic [31:0] ins, int rd, logic [31:0] value);
        add_entry(ins, '0, K_NONE, '0);
        if (rd != 0) model[rd] = value;   // r0 stays zero
    endtask

    task automatic put_store(int rt);
        add_entry(enc_i(SW, 0, rt, 16'h0040), '0, K_WDATA, model[rt]);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        for (int i = 0; i < NUM_REGS; i++) model[i] = '0;
        put_alu(enc_i(ADDI, 0, 1, 16'h1234), 1, 32'h1234);
        put_alu(enc_i(ADDI, 0, 3, 16'hfffb), 3, 32'hffff_fffb);
        put_alu(enc_i(LUI, 0, 2, 16'hf0f0), 2, 32'hf0f0_0000);
        put_alu(enc_i(ORI, 2, 4, 16'h00ff), 4, model[2] | 32'h00ff);
        put_store(4);
        put_alu(enc_r(ADD, 1, 3, 5, 0), 5, model[1] + model[3]);
        put_store(5);
        put_alu(enc_r(ADDU, 1, 2, 6, 0), 6, model[1] + model[2]);
        put_store(6);
        put_alu(enc_r(SUB, 1, 3, 7, 0), 7, model[1] - model[3]);
        put_store(7);
        put_alu(enc_r(SUBU, 3, 1, 8, 0), 8, model[3] - model[1]);
        put_store(8);
        put_alu(enc_r(AND, 2, 4, 9, 0), 9, model[2] & model[4]);
        put_store(9);
        put_alu(enc_r(OR, 1, 2, 10, 0), 10, model[1] | model[2]);
        put_store(10);
        put_alu(enc_r(XOR, 4, 1, 11, 0), 11, model[4] ^ model[1]);
        put_store(11);
        put_alu(enc_r(NOR, 1, 3, 12, 0), 12, ~(model[1] | model[3]));
        put_store(12);
        put_alu(enc_r(SLL, 0, 1, 13, 4), 13, model[1] << 4);
        put_store(13);
        put_alu(enc_r(SRL, 0, 2, 14, 8), 14, model[2] >> 8);
        put_store(14);
        put_alu(enc_r(SRA, 0, 2, 15, 8), 15, 32'($signed(model[2]) >>> 8));
        put_store(15);
        put_alu(enc_i(ADDI, 0, 16, 16'h0003), 16, 32'd3);
        put_alu(enc_r(SLLV, 16, 1, 17, 0), 17, model[1] << 3);
        put_store(17);
        put_alu(enc_r(SRLV, 16, 3, 18, 0), 18, model[3] >> 3);
        put_store(18);
        put_alu(enc_r(SLT, 3, 1, 19, 0), 19, 32'd1);   // -5 < 0x1234 signed
        put_store(19);
        put_alu(enc_r(SLT, 1, 3, 20, 0), 20, 32'd0);
        put_store(20);
        put_alu(enc_i(ANDI, 3, 21, 16'h0f0f), 21, model[3] & 32'h0f0f);
        put_store(21);
        put_alu(enc_i(XORI, 1, 22, 16'hffff), 22, model[1] ^ 32'hffff);
        put_store(22);
        put_alu(enc_i(ADDIU, 1, 23, 16'h8000), 23, model[1] + 32'h8000);
        put_store(23);
        add_entry(enc_i(SW, 1, 4, 16'hfff8), '0, K_ADDR, model[1] - 32'd8);
        rnd = $random(seed);
        add_entry(enc_i(LW, 0, 24, 16'h0010), rnd, K_NONE, '0);
        model[24] = rnd;
        put_store(24);
        add_entry(enc_i(BEQ, 1, 1, 16'h0003), '0, K_BRANCH, 32'd16);
        add_entry(enc_i(BEQ, 1, 3, 16'h0003), '0, K_NOBRANCH, '0);
        add_entry(enc_i(BNE, 1, 3, 16'hfffe), '0, K_BRANCH, 32'hffff_fffc);
        add_entry(enc_i(BNE, 1, 1, 16'hfffe), '0, K_NOBRANCH, '0);
        add_entry({J, 26'h012_3456}, '0, K_JUMP, {4'h0, 26'h012_3456, 2'b00});
        put_alu(enc_i(ADDI, 0, 0, 16'h0055), 0, 32'h55);
        put_store(0);
        add_entry(enc_r(SYSCALL, 0, 0, 0, 0), '0, K_HALT, '0);
        add_entry(enc_i(SW, 0, 1, 16'h0040), '0, K_NOWRITE, '0);
    endtask

    initial begin
        clk       = 1'b0;
        rst_b     = 1'b0;
        instr     = '0;
        mem_rdata = '0;
        run_done  = 1'b0;
        entry_id  = -1;
        cur_kind  = K_NONE;
        cur_exp   = '0;
        seed      = 32'hf766_3ada;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_b = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            instr     = tbl_instr[i];
            mem_rdata = tbl_rdata[i];
            cur_kind  = tbl_kind[i];
            cur_exp   = tbl_exp[i];
            entry_id  = i;
            @(negedge clk);
            while (wait_sig) @(negedge clk);   // hold the entry during the memory wait
        end
        instr    = '0;
        cur_kind = K_NONE;
        entry_id = n_entries;
        repeat (2) @(negedge clk);
        run_done = 1'b1;
        @(negedge clk);
        if (n_errors == 0 && n_tests == n_checks) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- tb/exec_core_monitor.sv
module exec_core_monitor (
    input  logic                        clk,
    input  logic                        rst_b,
    input  logic                        run_done,
    input  int                          entry_id,
    input  logic [3:0]                  kind,
    input  logic [mips_pkg::XLEN-1:0]   exp,
    input  logic [mips_pkg::XLEN-1:0]   mem_addr,
    input  logic [mips_pkg::XLEN-1:0]   mem_wdata,
    input  logic                        mem_we,
    input  logic [mips_pkg::XLEN-1:0]   pc_branch,
    input  logic                        pc_branch_en,
    input  logic [mips_pkg::PC_J_W-1:0] pc_j,
    input  logic                        pc_j_en,
    input  logic                        halted_signal,
    input  logic                        wait_sig,
    output int                          n_tests,
    output int                          n_errors
);
    import mips_pkg::*;
    `include "check_kinds.svh"

    int              cur_id;
    logic [3:0]      cur_kind;
    logic [XLEN-1:0] cur_exp;
    int              we_cnt;
    int              wait_cnt;
    logic            bad;
    string           msg;

    // registered outputs still show the finished entry at this edge
    task automatic finish_entry();
        case (cur_kind)
            K_WDATA, K_ADDR, K_NOWRITE: begin
                if (!bad && (we_cnt != ((cur_kind == K_NOWRITE) ? 0 : MEM_WAIT_CYCLES)
                        || wait_cnt != we_cnt)) begin
                    bad = 1'b1;
                    msg = $sformatf("mem_we high %0d cycles, wait_sig high %0d cycles",
                                    we_cnt, wait_cnt);
                end
            end
            K_BRANCH: if (!pc_branch_en || pc_branch !== cur_exp) begin
                bad = 1'b1;
                msg = $sformatf("branch en %b target %h, expected %h", pc_branch_en,
                                pc_branch, cur_exp);
            end
            K_NOBRANCH: if (pc_branch_en !== 1'b0) begin
                bad = 1'b1;
                msg = "branch taken with the condition false";
            end
            K_JUMP: if (!pc_j_en || pc_j !== cur_exp[PC_J_W-1:0]) begin
                bad = 1'b1;
                msg = $sformatf("jump en %b target %h, expected %h", pc_j_en, pc_j,
                                cur_exp[PC_J_W-1:0]);
            end
            K_HALT: if (halted_signal !== 1'b1) begin
                bad = 1'b1;
                msg = "halted_signal not set";
            end
            default: ;
        endcase
        if (cur_kind != K_NONE) begin
            n_tests++;
            if (bad) begin
                n_errors++;
                $display("[FAIL] %0t entry %0d: %s", $time, cur_id, msg);
            end else begin
                $display("[ok]   %0t entry %0d kind %0d", $time, cur_id, cur_kind);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_b) begin
            n_tests  = 0;
            n_errors = 0;
            cur_id   = -1;
        end else begin
            if (entry_id != cur_id) begin
                if (cur_id >= 0) finish_entry();
                cur_id   = entry_id;
                cur_kind = kind;
                cur_exp  = exp;
                we_cnt   = 0;
                wait_cnt = 0;
                bad      = 1'b0;
                // store data and address are valid from the first cycle
                if (cur_kind == K_WDATA && mem_wdata !== cur_exp) begin
                    bad = 1'b1;
                    msg = $sformatf("mem_wdata %h, expected %h", mem_wdata, cur_exp);
                end else if (cur_kind == K_ADDR && mem_addr !== cur_exp) begin
                    bad = 1'b1;
                    msg = $sformatf("mem_addr %h, expected %h", mem_addr, cur_exp);
                end
            end
            if (mem_we) we_cnt++;
            if (wait_sig) wait_cnt++;
        end
    end

    always @(posedge run_done) begin
        $display("checks run %0d, errors %0d", n_tests, n_errors);
    end

endmodule

//--- tb/exec_core_chk.sv
module exec_core_chk (
    input logic clk,
    input logic rst_b,
    input logic wait_sig,
    input logic halted_signal,
    input logic halt_req,
    input logic wb_we,
    input logic mem_we
);
    import mips_pkg::*;

    int high_cnt;   // consecutive cycles with wait_sig high

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            high_cnt <= 0;
        end else if (wait_sig) begin
            high_cnt <= high_cnt + 1;
        end else begin
            high_cnt <= 0;
        end
    end

    wait_length: assert property (@(posedge clk) disable iff (!rst_b)
        $fell(wait_sig) |-> (high_cnt == MEM_WAIT_CYCLES))
        else $error("wait_sig was not high for exactly %0d cycles", MEM_WAIT_CYCLES);

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_b)
        halted_signal |=> halted_signal)
        else $error("halted_signal fell without a reset");

    // the halting instruction itself must not write either
    no_write_halted: assert property (@(posedge clk) disable iff (!rst_b)
        (halted_signal || halt_req) |-> (!wb_we && !mem_we))
        else $error("write enable active while halted");

endmodule

bind step_ctrl exec_core_chk u_chk (
    .clk(clk), .rst_b(rst_b), .wait_sig(wait_sig), .halted_signal(halted_signal),
    .halt_req(halt_req), .wb_we(wb_we), .mem_we(mem_req_out.we)
);

//--- logic/exec_core.sv
module exec_core (
    input  logic                        clk,
    input  logic                        rst_b,
    input  logic [mips_pkg::XLEN-1:0]   instr,
    input  logic [mips_pkg::XLEN-1:0]   mem_rdata,
    output logic [mips_pkg::XLEN-1:0]   mem_addr,
    output logic [mips_pkg::XLEN-1:0]   mem_wdata,
    output logic                        mem_we,
    output logic [mips_pkg::XLEN-1:0]   pc_branch,
    output logic                        pc_branch_en,
    output logic [mips_pkg::PC_J_W-1:0] pc_j,
    output logic                        pc_j_en,
    output logic                        halted_signal,
    output logic                        wait_sig
);
    import mips_pkg::*;

    logic [REG_ADDR_W-1:0] rs_num;
    logic [REG_ADDR_W-1:0] rt_num;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       rd_data;
    logic                  rd_we;
    logic                  halt_req;
    alu_req_t              alu_req;
    wb_req_t               wb_req;
    mem_req_t              mem_req;
    mem_req_t              mem_req_gated;
    redirect_t             redirect;

    assign rd_data   = wb_req.sel_mem ? mem_rdata : alu_result;   // lw takes memory data
    assign mem_addr  = mem_req_gated.addr;
    assign mem_wdata = mem_req_gated.wdata;
    assign mem_we    = mem_req_gated.we;

    instr_decoder u_decoder (
        .instr(instr), .rs_data(rs_data), .rt_data(rt_data), .alu_result(alu_result),
        .rs_num(rs_num), .rt_num(rt_num), .alu_req(alu_req), .wb_req(wb_req),
        .mem_req(mem_req), .redirect(redirect), .halt_req(halt_req)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_b(rst_b), .rs_num(rs_num), .rt_num(rt_num), .rd_num(wb_req.rd),
        .rd_data(rd_data), .rd_we(rd_we), .rs_data(rs_data), .rt_data(rt_data)
    );

    alu u_alu (
        .req(alu_req), .result(alu_result)
    );

    step_ctrl u_step_ctrl (
        .clk(clk), .rst_b(rst_b), .mem_req_in(mem_req), .redirect_in(redirect),
        .halt_req(halt_req), .wb_we_in(wb_req.we), .mem_req_out(mem_req_gated),
        .wb_we(rd_we), .wait_sig(wait_sig), .pc_branch(pc_branch),
        .pc_branch_en(pc_branch_en), .pc_j(pc_j), .pc_j_en(pc_j_en),
        .halted_signal(halted_signal)
    );

endmodule

//--- logic/step_ctrl.sv
module step_ctrl (
    input  logic                        clk,
    input  logic                        rst_b,
    input  mips_pkg::mem_req_t          mem_req_in,
    input  mips_pkg::redirect_t         redirect_in,
    input  logic                        halt_req,
    input  logic                        wb_we_in,
    output mips_pkg::mem_req_t          mem_req_out,
    output logic                        wb_we,
    output logic                        wait_sig,
    output logic [mips_pkg::XLEN-1:0]   pc_branch,
    output logic                        pc_branch_en,
    output logic [mips_pkg::PC_J_W-1:0] pc_j,
    output logic                        pc_j_en,
    output logic                        halted_signal
);
    import mips_pkg::*;

    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic                  mem_start;
    logic                  last_wait;

    assign mem_start = (mem_req_in.we || mem_req_in.re) && !wait_sig && !halted_signal;
    assign last_wait = wait_sig && (wait_cnt == WAIT_CNT_W'(MEM_WAIT_CYCLES - 1));

    // memory wait counter
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            wait_sig <= 1'b0;
            wait_cnt <= '0;
        end else if (mem_start) begin
            wait_sig <= 1'b1;
            wait_cnt <= '0;
        end else if (last_wait) begin
            wait_sig <= 1'b0;
            wait_cnt <= '0;
        end else if (wait_sig) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // redirect and halt frozen during the wait
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            pc_branch_en  <= 1'b0;
            pc_j_en       <= 1'b0;
            halted_signal <= 1'b0;
        end else if (!wait_sig) begin
            pc_branch_en  <= redirect_in.branch_en;
            pc_j_en       <= redirect_in.j_en;
            halted_signal <= halted_signal || halt_req;   // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (!wait_sig) begin
            pc_branch <= redirect_in.branch_target;
            pc_j      <= redirect_in.j_target;
        end
    end

    // lw writes on the last wait cycle, everything else outside the wait
    assign wb_we = wb_we_in && !halted_signal && (mem_req_in.re ? last_wait : !wait_sig);

    always_comb begin
        mem_req_out    = mem_req_in;
        mem_req_out.we = mem_req_in.we && wait_sig && !halted_signal;
        mem_req_out.re = mem_req_in.re && wait_sig && !halted_signal;
    end

endmodule

//--- logic/alu.sv
module alu (
    input  mips_pkg::alu_req_t        req,
    output logic [mips_pkg::XLEN-1:0] result
);
    import mips_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = req.b[SHAMT_W-1:0];   // only low bits count

    always_comb begin
        case (req.op)
            ALU_ADD: result = req.a + req.b;
            ALU_SUB: result = req.a - req.b;
            ALU_AND: result = req.a & req.b;
            ALU_OR:  result = req.a | req.b;
            ALU_XOR: result = req.a ^ req.b;
            ALU_NOR: result = ~(req.a | req.b);
            ALU_SLL: result = req.a << shamt;
            ALU_SRL: result = req.a >> shamt;
            ALU_SRA: result = $signed(req.a) >>> shamt;      // sign fill
            ALU_SLT: result = XLEN'($signed(req.a) < $signed(req.b));
            ALU_EQ:  result = XLEN'(req.a == req.b);         // branch compare
            default: result = '0;
        endcase
    end

endmodule

//--- logic/reg_file.sv
module reg_file (
    input  logic                            clk,
    input  logic                            rst_b,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rs_num,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rt_num,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rd_num,
    input  logic [mips_pkg::XLEN-1:0]       rd_data,
    input  logic                            rd_we,
    output logic [mips_pkg::XLEN-1:0]       rs_data,
    output logic [mips_pkg::XLEN-1:0]       rt_data
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_num != '0)) begin   // r0 is hardwired
            regs[rd_num] <= rd_data;
        end
    end

    // async read, r0 forced to zero
    assign rs_data = (rs_num == '0) ? '0 : regs[rs_num];
    assign rt_data = (rt_num == '0) ? '0 : regs[rt_num];

endmodule

//--- decode/instr_decoder.sv
module instr_decoder (
    input  logic [mips_pkg::XLEN-1:0]       instr,
    input  logic [mips_pkg::XLEN-1:0]       rs_data,
    input  logic [mips_pkg::XLEN-1:0]       rt_data,
    input  logic [mips_pkg::XLEN-1:0]       alu_result,
    output logic [mips_pkg::REG_ADDR_W-1:0] rs_num,
    output logic [mips_pkg::REG_ADDR_W-1:0] rt_num,
    output mips_pkg::alu_req_t              alu_req,
    output mips_pkg::wb_req_t               wb_req,
    output mips_pkg::mem_req_t              mem_req,
    output mips_pkg::redirect_t             redirect,
    output logic                            halt_req
);
    import mips_pkg::*;

    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rd_field;
    logic [SHAMT_W-1:0]    shamt;
    logic [IMM_W-1:0]      imm;
    logic [JADDR_W-1:0]    jaddr;
    logic [XLEN-1:0]       imm_sext;
    logic [XLEN-1:0]       imm_zext;
    logic [XLEN-1:0]       br_offset;
    logic                  is_beq;
    logic                  is_bne;
    logic                  is_j;
    logic                  is_lw;
    logic                  is_sw;

    // field split
    assign opcode   = opcode_e'(instr[31:26]);
    assign rs_num   = instr[25:21];
    assign rt_num   = instr[20:16];
    assign rd_field = instr[15:11];
    assign shamt    = instr[10:6];
    assign funct    = funct_e'(instr[5:0]);
    assign imm      = instr[IMM_W-1:0];
    assign jaddr    = instr[JADDR_W-1:0];

    assign imm_sext  = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    assign imm_zext  = {{(XLEN-IMM_W){1'b0}}, imm};
    assign br_offset = {imm_sext[XLEN-3:0], 2'b00} + XLEN'(4);

    assign is_beq = (opcode == BEQ);
    assign is_bne = (opcode == BNE);
    assign is_j   = (opcode == J);
    assign is_lw  = (opcode == LW);
    assign is_sw  = (opcode == SW);

    // operand select and writeback control
    always_comb begin
        alu_req  = '{a: rs_data, b: rt_data, op: ALU_ADD};
        wb_req   = '{we: 1'b0, rd: rd_field, sel_mem: 1'b0};
        halt_req = 1'b0;
        case (opcode)
            R_TYPE: begin
                wb_req.we = 1'b1;
                case (funct)
                    ADD, ADDU: alu_req.op = ALU_ADD;
                    SUB, SUBU: alu_req.op = ALU_SUB;
                    AND:       alu_req.op = ALU_AND;
                    OR:        alu_req.op = ALU_OR;
                    XOR:       alu_req.op = ALU_XOR;
                    NOR:       alu_req.op = ALU_NOR;
                    SLT:       alu_req.op = ALU_SLT;
                    SLL, SRL, SRA: begin
                        alu_req.a = rt_data;
                        alu_req.b = XLEN'(shamt);          // fixed shift amount
                        alu_req.op = (funct == SLL) ? ALU_SLL :
                                     (funct == SRL) ? ALU_SRL : ALU_SRA;
                    end
                    SLLV, SRLV: begin
                        alu_req.a  = rt_data;
                        alu_req.b  = rs_data;              // alu keeps the low bits
                        alu_req.op = (funct == SLLV) ? ALU_SLL : ALU_SRL;
                    end
                    SYSCALL: begin
                        wb_req.we = 1'b0;
                        halt_req  = 1'b1;
                    end
                    default: begin
                        wb_req.we = 1'b0;
                        halt_req  = 1'b1;                  // unknown funct
                    end
                endcase
            end
            ADDI, ADDIU, ANDI, ORI, XORI: begin
                wb_req.we = 1'b1;
                wb_req.rd = rt_num;
                alu_req.b = (opcode == ADDI) ? imm_sext : imm_zext;
                case (opcode)
                    ANDI:    alu_req.op = ALU_AND;
                    ORI:     alu_req.op = ALU_OR;
                    XORI:    alu_req.op = ALU_XOR;
                    default: alu_req.op = ALU_ADD;
                endcase
            end
            LUI: begin
                wb_req.we = 1'b1;
                wb_req.rd = rt_num;
                alu_req.a = '0;                            // 0 + upper immediate
                alu_req.b = {imm, {(XLEN-IMM_W){1'b0}}};
            end
            BEQ, BNE: alu_req.op = ALU_EQ;
            LW: begin
                alu_req.b      = imm_sext;                 // address through the alu
                wb_req.we      = 1'b1;
                wb_req.rd      = rt_num;
                wb_req.sel_mem = 1'b1;
            end
            SW: alu_req.b = imm_sext;
            J: ;
            default: halt_req = 1'b1;
        endcase
    end

    // consumers of the alu result
    assign mem_req = '{addr: alu_result, wdata: rt_data, we: is_sw, re: is_lw};

    assign redirect = '{
        branch_en:     (is_beq && alu_result[0]) || (is_bne && !alu_result[0]),
        branch_target: br_offset,
        j_en:          is_j,
        j_target:      {jaddr, 2'b00}
    };

endmodule

//--- common/mips_pkg.sv
package mips_pkg;

    localparam int XLEN            = 32;
    localparam int REG_ADDR_W      = 5;
    localparam int NUM_REGS        = 32;
    localparam int IMM_W           = 16;
    localparam int JADDR_W         = 26;
    localparam int PC_J_W          = JADDR_W + 2;     // jump field plus the word offset
    localparam int SHAMT_W         = $clog2(XLEN);
    localparam int MEM_WAIT_CYCLES = 5;
    localparam int WAIT_CNT_W      = $clog2(MEM_WAIT_CYCLES);

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        R_TYPE = 6'b000000,
        J      = 6'b000010,
        BEQ    = 6'b000100,
        BNE    = 6'b000101,
        ADDI   = 6'b001000,
        ADDIU  = 6'b001001,
        ANDI   = 6'b001100,
        ORI    = 6'b001101,
        XORI   = 6'b001110,
        LUI    = 6'b001111,
        LW     = 6'b100011,
        SW     = 6'b101011
    } opcode_e;

    // function code, instr[5:0] of R_TYPE
    typedef enum logic [5:0] {
        SLL     = 6'b000000,
        SRL     = 6'b000010,
        SRA     = 6'b000011,
        SLLV    = 6'b000100,
        SRLV    = 6'b000110,
        SYSCALL = 6'b001100,
        ADD     = 6'b100000,
        ADDU    = 6'b100001,
        SUB     = 6'b100010,
        SUBU    = 6'b100011,
        AND     = 6'b100100,
        OR      = 6'b100101,
        XOR     = 6'b100110,
        NOR     = 6'b100111,
        SLT     = 6'b101010
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_EQ
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;                 // shift amount in low bits for shifts
        alu_op_e         op;
    } alu_req_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic                  sel_mem;     // write back mem_rdata, not the alu
    } wb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            we;
        logic            re;
    } mem_req_t;

    typedef struct packed {
        logic              branch_en;
        logic [XLEN-1:0]   branch_target;   // pc-relative offset
        logic              j_en;
        logic [PC_J_W-1:0] j_target;
    } redirect_t;

endpackage
